// ==== Bender.yml ====
package:
  name: dcache

sources:
  # cache RTL, package first
  - include_dirs:
      - logic
    files:
      - logic/dcache_pkg.sv
      - logic/dcache_mem.sv
      - logic/dcache_biu.sv
      - logic/dcache_hit.sv
      - logic/dcache_top.sv

  # testbench, top module tb_dcache
  - target: test
    include_dirs:
      - logic
    files:
      - verification/tb_clkgen.sv
      - verification/tb_bus_mem.sv
      - verification/tb_dcache.sv

// ==== logic/dcache_biu.sv ====
////////////////////
// bus interface unit of the data cache, sole owner of the bus
// runs a 4-beat line burst or one single-word read
////////////////////

`timescale 1ns/100ps

`include "dcache_macros.svh"

module dcache_biu (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  dcache_pkg::dc_biucmd_e biucmd_i,
  input  dcache_pkg::dc_addr_t   adr_i,
  input  logic                   bus_ack_i,
  input  dcache_pkg::dc_word_t   bus_rdata_i,
  input  logic                   bus_err_i,
  output logic                   bus_req_o,
  output dcache_pkg::dc_addr_t   bus_adr_o,
  output logic                   done_o,
  output logic                   err_o,
  output dcache_pkg::dc_line_t   line_o,
  output dcache_pkg::dc_word_t   word_o
);

  import dcache_pkg::*;

  localparam int CNT_BITS = $clog2(`DC_LINE_WORDS);

  logic                busy_q;
  // burst or single read
  logic                burst_q;
  // transfer over, wait for the command to go back to NOP
  logic                hold_q;
  logic [CNT_BITS-1:0] beat_cnt_q;
  logic                line_done_q;
  dc_addr_t            adr_q;
  dc_line_t            line_q;

  logic                beat_ok;
  logic                beat_err;
  logic                last_beat;

  assign beat_ok   = busy_q & bus_ack_i;
  assign beat_err  = busy_q & bus_err_i;
  assign last_beat = ~burst_q | (beat_cnt_q == CNT_BITS'(`DC_LINE_WORDS-1));

  ////////////////////
  // transfer control
  ////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy_q      <= 1'b0;
      burst_q     <= 1'b0;
      hold_q      <= 1'b0;
      beat_cnt_q  <= '0;
      line_done_q <= 1'b0;
    end
    else
    begin
      line_done_q <= beat_ok & last_beat & burst_q;

      if (beat_err)
      begin
        // error ends it at once
        busy_q <= 1'b0;
        hold_q <= 1'b1;
      end
      else if (beat_ok)
      begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (last_beat)
        begin
          busy_q <= 1'b0;
          hold_q <= 1'b1;
        end
      end
      else if (!busy_q)
      begin
        if (hold_q)
        begin
          if (biucmd_i == BIUCMD_NOP)
            hold_q <= 1'b0;
        end
        else if (biucmd_i != BIUCMD_NOP)
        begin
          busy_q     <= 1'b1;
          burst_q    <= (biucmd_i == BIUCMD_READWAY);
          beat_cnt_q <= '0;
        end
      end
    end
  end

  ////////////////////
  // address and line assembly
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (!busy_q && !hold_q && biucmd_i != BIUCMD_NOP)
      adr_q <= adr_i;
    else if (beat_ok)
    begin
      // next word of the line
      adr_q  <= adr_q + dc_addr_t'(`DC_XLEN/8);
      // beats enter at the top, beat 0 ends up in word 0
      line_q <= {bus_rdata_i, line_q[$bits(dc_line_t)-1:`DC_XLEN]};
    end
  end

  assign bus_req_o = busy_q;
  assign bus_adr_o = adr_q;

  // single read completes with its ack, a burst one cycle after the last ack
  assign done_o = line_done_q | (beat_ok & ~burst_q);
  assign err_o  = beat_err;
  assign line_o = line_q;
  assign word_o = bus_rdata_i;

endmodule

// ==== logic/dcache_hit.sv ====
////////////////////
// hit stage of the data cache
// decides hit, miss, non-cacheable read and flush
// drives stall, the read result and the bus command
////////////////////

`timescale 1ns/100ps

`include "dcache_macros.svh"

module dcache_hit (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  dcache_pkg::dc_addr_t   adr_i,
  input  logic                   cacheable_i,
  input  logic                   cacheflush_req_i,
  input  logic                   hit_i,
  input  dcache_pkg::dc_line_t   hit_line_i,
  input  dcache_pkg::dc_way_t    repl_way_i,
  input  logic                   flush_done_i,
  input  logic                   biu_done_i,
  input  logic                   biu_err_i,
  input  dcache_pkg::dc_line_t   biu_line_i,
  input  dcache_pkg::dc_word_t   biu_word_i,
  output logic                   stall_o,
  output dcache_pkg::dc_word_t   rdata_o,
  output logic                   rvalid_o,
  output logic                   err_o,
  output logic                   armed_o,
  output logic                   flush_start_o,
  output logic                   fill_we_o,
  output dcache_pkg::dc_way_t    fill_way_o,
  output dcache_pkg::dc_line_t   fill_line_o,
  output dcache_pkg::dc_biucmd_e biucmd_o,
  output dcache_pkg::dc_addr_t   biu_adr_o
);

  import dcache_pkg::*;

  ////////////////////
  // constants
  ////////////////////

  localparam int WOFFS_LSB  = $clog2(`DC_XLEN/8);
  localparam int WOFFS_BITS = $clog2(`DC_LINE_WORDS);
  localparam int LINE_BITS  = `DC_PLEN - `DC_OFFS_BITS;

  dc_hit_state_e          state_q;

  // way and line of the pending miss
  dc_way_t                fill_way_q;
  logic [LINE_BITS-1:0]   miss_line_q;

  logic [WOFFS_BITS-1:0]  woffs;
  dc_word_t               hit_word;
  dc_word_t               fill_word;
  logic                   cache_ack;
  logic                   nc_start;
  logic                   miss_start;
  logic                   in_miss_line;

  ////////////////////
  // decode
  ////////////////////

  assign woffs     = adr_i[WOFFS_LSB +: WOFFS_BITS];
  assign hit_word  = hit_line_i[woffs*`DC_XLEN +: `DC_XLEN];
  assign fill_word = biu_line_i[woffs*`DC_XLEN +: `DC_XLEN];

  assign cache_ack  = req_i & cacheable_i & hit_i;
  // flush request wins in ARMED
  assign nc_start   = req_i & ~cacheable_i & ~cacheflush_req_i;
  assign miss_start = req_i & cacheable_i & ~hit_i & ~cacheflush_req_i;

  assign in_miss_line = (adr_i[`DC_PLEN-1:`DC_OFFS_BITS] == miss_line_q);

  // burst from the line base, single read from the word
  assign biu_adr_o = cacheable_i
                   ? {adr_i[`DC_PLEN-1:`DC_OFFS_BITS], {`DC_OFFS_BITS{1'b0}}}
                   : {adr_i[`DC_PLEN-1:WOFFS_LSB], {WOFFS_LSB{1'b0}}};

  ////////////////////
  // state machine
  ////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q  <= ARMED;
      biucmd_o <= BIUCMD_NOP;
    end
    else
    begin
      unique case (state_q)
        ARMED:
          if (cacheflush_req_i)
            state_q <= FLUSH;
          else if (nc_start)
          begin
            state_q  <= NONCACHEABLE;
            biucmd_o <= BIUCMD_READWORD;
          end
          else if (miss_start)
          begin
            state_q  <= WAIT4FILL;
            biucmd_o <= BIUCMD_READWAY;
          end

        // memory walks the sets
        FLUSH:
          if (flush_done_i)
            state_q <= RECOVER;

        NONCACHEABLE:
          if (biu_done_i || biu_err_i)
          begin
            state_q  <= ARMED;
            biucmd_o <= BIUCMD_NOP;
          end

        WAIT4FILL:
          if (biu_done_i || biu_err_i)
          begin
            state_q  <= RECOVER;
            biucmd_o <= BIUCMD_NOP;
          end

        // one lookup after the store changed
        RECOVER:
          state_q <= ARMED;

        default:
          state_q <= ARMED;
      endcase
    end
  end

  // latch victim way and line on a miss
  always_ff @(posedge clk_i)
  begin
    if (state_q == ARMED && miss_start)
    begin
      fill_way_q  <= repl_way_i;
      miss_line_q <= adr_i[`DC_PLEN-1:`DC_OFFS_BITS];
    end
  end

  ////////////////////
  // core and memory side
  ////////////////////

  always_comb
  begin
    rvalid_o      = 1'b0;
    err_o         = 1'b0;
    rdata_o       = hit_word;
    fill_we_o     = 1'b0;
    flush_start_o = 1'b0;

    unique case (state_q)
      ARMED:
      begin
        flush_start_o = cacheflush_req_i;
        rvalid_o      = cache_ack & ~cacheflush_req_i;
      end

      NONCACHEABLE:
      begin
        rdata_o  = biu_word_i;
        rvalid_o = biu_done_i;
        err_o    = biu_err_i;
      end

      // write the line, serve the word straight from it
      WAIT4FILL:
      begin
        fill_we_o = biu_done_i;
        rdata_o   = fill_word;
        rvalid_o  = biu_done_i & req_i & cacheable_i & in_miss_line;
        err_o     = biu_err_i;
      end

      RECOVER:
        rvalid_o = cache_ack;

      default:
        rvalid_o = 1'b0;
    endcase

    // anything not answered this cycle waits
    stall_o = req_i & ~(rvalid_o | err_o);
  end

  assign armed_o     = (state_q == ARMED);
  assign fill_way_o  = fill_way_q;
  assign fill_line_o = biu_line_i;

endmodule

// ==== logic/dcache_macros.svh ====
////////////////////
// geometry and bus constants for the read-only data cache
// include wherever a width or count is needed
////////////////////

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// data and address width
`define DC_XLEN        32
`define DC_PLEN        32

// 2-way, 8-set store
`define DC_WAYS        2
`define DC_SETS        8

// 16-byte lines, four words each
`define DC_LINE_WORDS  4

// address split: tag | index | byte offset
`define DC_IDX_BITS    3
`define DC_OFFS_BITS   4
`define DC_TAG_BITS    25

`endif

// ==== logic/dcache_mem.sv ====
////////////////////
// tag, valid, replacement and data store of the data cache
// combinational lookup, line write from the hit stage
// and a set-by-set flush walk
////////////////////

`timescale 1ns/100ps

`include "dcache_macros.svh"

module dcache_mem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dcache_pkg::dc_addr_t lookup_adr_i,
  input  logic                 fill_we_i,
  input  dcache_pkg::dc_way_t  fill_way_i,
  input  dcache_pkg::dc_line_t fill_line_i,
  input  logic                 flush_start_i,
  output logic                 hit_o,
  output dcache_pkg::dc_line_t hit_line_o,
  output dcache_pkg::dc_way_t  repl_way_o,
  output logic                 flush_done_o
);

  import dcache_pkg::*;

  ////////////////////
  // storage
  ////////////////////

  // tag and line of each way and set
  dc_tag_t  tag_q  [`DC_WAYS][`DC_SETS];
  dc_line_t data_q [`DC_WAYS][`DC_SETS];

  // one valid bit per way
  dc_way_t  valid_q [`DC_SETS];
  // way to replace next in each set
  logic [`DC_SETS-1:0] repl_q;

  logic     flushing_q;
  dc_idx_t  flush_cnt_q;

  dc_idx_t  idx;
  dc_tag_t  tag;
  dc_way_t  way_hit;

  ////////////////////
  // lookup
  ////////////////////

  assign idx = lookup_adr_i[`DC_OFFS_BITS +: `DC_IDX_BITS];
  assign tag = lookup_adr_i[`DC_PLEN-1 -: `DC_TAG_BITS];

  // compare both ways and or in the hitting line
  always_comb
  begin
    hit_line_o = '0;
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      way_hit[w] = valid_q[idx][w] && (tag_q[w][idx] == tag);
      hit_line_o = hit_line_o | ({$bits(dc_line_t){way_hit[w]}} & data_q[w][idx]);
    end
  end

  assign hit_o      = |way_hit;
  assign repl_way_o = dc_way_t'(1) << repl_q[idx];

  // last set of the walk
  assign flush_done_o = flushing_q && (flush_cnt_q == dc_idx_t'(`DC_SETS-1));

  ////////////////////
  // line write
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      if (fill_we_i && fill_way_i[w])
      begin
        tag_q[w][idx]  <= tag;
        data_q[w][idx] <= fill_line_i;
      end
    end
  end

  // valid bits, replacement and flush walk
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int s = 0; s < `DC_SETS; s++)
        valid_q[s] <= '0;
      repl_q      <= '0;
      flushing_q  <= 1'b0;
      flush_cnt_q <= '0;
    end
    else
    begin
      // walk one set per cycle
      if (flush_start_i)
      begin
        flushing_q  <= 1'b1;
        flush_cnt_q <= '0;
      end
      else if (flushing_q)
      begin
        valid_q[flush_cnt_q] <= '0;
        flush_cnt_q          <= flush_cnt_q + 1'b1;
        if (flush_done_o)
          flushing_q <= 1'b0;
      end

      // point away from the way just filled or hit
      if (fill_we_i)
      begin
        valid_q[idx] <= valid_q[idx] | fill_way_i;
        repl_q[idx]  <= fill_way_i[0];
      end
      else if (hit_o)
        repl_q[idx] <= way_hit[0];
    end
  end

endmodule

// ==== logic/dcache_pkg.sv ====
////////////////////
// shared types of the data cache
// vector typedefs, bus command and hit stage state
////////////////////

`include "dcache_macros.svh"

package dcache_pkg;

  ////////////////////
  // widths with a meaning
  ////////////////////

  // byte address
  typedef logic [`DC_PLEN-1:0]                   dc_addr_t;
  // one data word
  typedef logic [`DC_XLEN-1:0]                   dc_word_t;
  // full line, word 0 in the low bits
  typedef logic [`DC_LINE_WORDS*`DC_XLEN-1:0]    dc_line_t;
  typedef logic [`DC_TAG_BITS-1:0]               dc_tag_t;
  typedef logic [`DC_IDX_BITS-1:0]               dc_idx_t;
  // one-hot way select
  typedef logic [`DC_WAYS-1:0]                   dc_way_t;

  ////////////////////
  // state machines
  ////////////////////

  // command from hit stage to bus interface unit, held as a level
  typedef enum logic [1:0] {
    BIUCMD_NOP,
    BIUCMD_READWAY,
    BIUCMD_READWORD
  } dc_biucmd_e;

  typedef enum logic [2:0] {
    ARMED,
    FLUSH,
    NONCACHEABLE,
    WAIT4FILL,
    RECOVER
  } dc_hit_state_e;

endpackage

// ==== logic/dcache_top.sv ====
////////////////////
// read-only data cache for a 32-bit load path
// hit stage, tag and data store, bus interface unit
////////////////////

`timescale 1ns/100ps

module dcache_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // core side
  input  logic                 req_i,
  input  dcache_pkg::dc_addr_t adr_i,
  input  logic                 cacheable_i,
  input  logic                 cacheflush_req_i,
  output logic                 stall_o,
  output dcache_pkg::dc_word_t rdata_o,
  output logic                 rvalid_o,
  output logic                 err_o,
  output logic                 armed_o,

  // bus side
  output logic                 bus_req_o,
  output dcache_pkg::dc_addr_t bus_adr_o,
  input  logic                 bus_ack_i,
  input  dcache_pkg::dc_word_t bus_rdata_i,
  input  logic                 bus_err_i
);

  import dcache_pkg::*;

  ////////////////////
  // internal wires
  ////////////////////

  // memory lookup
  logic       hit;
  dc_line_t   hit_line;
  dc_way_t    repl_way;

  // line write and flush
  logic       fill_we;
  dc_way_t    fill_way;
  dc_line_t   fill_line;
  logic       flush_start;
  logic       flush_done;

  // bus interface unit
  dc_biucmd_e biucmd;
  dc_addr_t   biu_adr;
  logic       biu_done;
  logic       biu_err;
  dc_line_t   biu_line;
  dc_word_t   biu_word;

  dcache_hit u_hit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .adr_i            (adr_i),
    .cacheable_i      (cacheable_i),
    .cacheflush_req_i (cacheflush_req_i),
    .hit_i            (hit),
    .hit_line_i       (hit_line),
    .repl_way_i       (repl_way),
    .flush_done_i     (flush_done),
    .biu_done_i       (biu_done),
    .biu_err_i        (biu_err),
    .biu_line_i       (biu_line),
    .biu_word_i       (biu_word),
    .stall_o          (stall_o),
    .rdata_o          (rdata_o),
    .rvalid_o         (rvalid_o),
    .err_o            (err_o),
    .armed_o          (armed_o),
    .flush_start_o    (flush_start),
    .fill_we_o        (fill_we),
    .fill_way_o       (fill_way),
    .fill_line_o      (fill_line),
    .biucmd_o         (biucmd),
    .biu_adr_o        (biu_adr)
  );

  // lookup address is the held core address
  dcache_mem u_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_adr_i  (adr_i),
    .fill_we_i     (fill_we),
    .fill_way_i    (fill_way),
    .fill_line_i   (fill_line),
    .flush_start_i (flush_start),
    .hit_o         (hit),
    .hit_line_o    (hit_line),
    .repl_way_o    (repl_way),
    .flush_done_o  (flush_done)
  );

  dcache_biu u_biu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .biucmd_i    (biucmd),
    .adr_i       (biu_adr),
    .bus_ack_i   (bus_ack_i),
    .bus_rdata_i (bus_rdata_i),
    .bus_err_i   (bus_err_i),
    .bus_req_o   (bus_req_o),
    .bus_adr_o   (bus_adr_o),
    .done_o      (biu_done),
    .err_o       (biu_err),
    .line_o      (biu_line),
    .word_o      (biu_word)
  );

endmodule

// ==== verification/tb_bus_mem.sv ====
////////////////////
// behavioral bus memory for the cache testbench
// one beat per request with random wait cycles
// data follows the word address, bit 30 marks the error region
////////////////////

`timescale 1ns/100ps

module tb_bus_mem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 bus_req_i,
  input  dcache_pkg::dc_addr_t bus_adr_i,
  output logic                 bus_ack_o,
  output dcache_pkg::dc_word_t bus_rdata_o,
  output logic                 bus_err_o
);

  import dcache_pkg::*;

  // address bit that selects the error region
  localparam int       ERR_BIT   = 30;
  localparam dc_word_t DATA_MASK = 32'h5a5a_0000;

  integer      seed;
  logic [31:0] rnd;
  // wait cycles left before the next answer
  logic [1:0]  wait_cnt;

  // aligned word address with the fixed pattern
  function automatic dc_word_t mem_word(input dc_addr_t a);
    return {a[31:2], 2'b00} ^ DATA_MASK;
  endfunction

  // defined outputs before the first reset edge
  initial
  begin
    seed        = 32'hb05ca591;
    bus_ack_o   = 1'b0;
    bus_err_o   = 1'b0;
    bus_rdata_o = '0;
    wait_cnt    = '0;
  end

  always @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bus_ack_o <= 1'b0;
      bus_err_o <= 1'b0;
      wait_cnt  <= '0;
    end
    else
    begin
      bus_ack_o <= 1'b0;
      bus_err_o <= 1'b0;
      // one answer per beat, skip the cycle the answer is seen
      if (bus_req_i && !bus_ack_o && !bus_err_o)
      begin
        if (wait_cnt != 2'd0)
          wait_cnt <= wait_cnt - 2'd1;
        else
        begin
          if (bus_adr_i[ERR_BIT])
            bus_err_o <= 1'b1;
          else
          begin
            bus_ack_o   <= 1'b1;
            bus_rdata_o <= mem_word(bus_adr_i);
          end
          // delay of the following beat, 0 to 3
          rnd = $random(seed);
          wait_cnt <= rnd[1:0];
        end
      end
    end
  end

endmodule

// ==== verification/tb_clkgen.sv ====
////////////////////
// clock and reset source of the cache testbench
// free-running clock, active low reset for a few cycles
////////////////////

`timescale 1ns/100ps

module tb_clkgen #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // clock starts low, first rising edge after half a period
  initial
  begin
    clk_o = 1'b0;
    forever
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // release on a rising edge, after the flops have sampled it
  initial
  begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== verification/tb_dcache.sv ====
////////////////////
// testbench of the read-only data cache
// runs a table of reads and flushes against the DUT
// and checks data, errors, stall and bus use per row
////////////////////

`timescale 1ns/100ps

`include "dcache_macros.svh"

module tb_dcache;

  import dcache_pkg::*;

  // watchdog budget per table row
  localparam int ROW_CYCLES = 200;

  typedef enum logic [1:0] {OP_READ, OP_FLUSH} op_e;
  typedef enum logic [1:0] {EXP_DATA, EXP_ERR, EXP_FLUSH} exp_e;

  logic     clk;
  logic     rst_n;

  // core side
  logic     req;
  dc_addr_t adr;
  logic     cacheable;
  logic     flush_req;
  logic     stall;
  dc_word_t rdata;
  logic     rvalid;
  logic     err;
  logic     armed;

  // bus side
  logic     bus_req;
  dc_addr_t bus_adr;
  logic     bus_ack;
  dc_word_t bus_rdata;
  logic     bus_err;

  ////////////////////
  // stimulus and expect table
  ////////////////////

  op_e      row_op    [$];
  dc_addr_t row_adr   [$];
  logic     row_cache [$];
  exp_e     row_exp   [$];
  dc_word_t row_word  [$];
  // 1 when the row must reach the bus
  logic     row_bus   [$];

  logic     table_ready;
  int       row_errs;
  int       tests_passed;
  int       tests_failed;

  tb_clkgen #(
    .PERIOD_NS  (8.0),
    .RST_CYCLES (4)
  ) u_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  dcache_top DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_i            (req),
    .adr_i            (adr),
    .cacheable_i      (cacheable),
    .cacheflush_req_i (flush_req),
    .stall_o          (stall),
    .rdata_o          (rdata),
    .rvalid_o         (rvalid),
    .err_o            (err),
    .armed_o          (armed),
    .bus_req_o        (bus_req),
    .bus_adr_o        (bus_adr),
    .bus_ack_i        (bus_ack),
    .bus_rdata_i      (bus_rdata),
    .bus_err_i        (bus_err)
  );

  tb_bus_mem u_bus_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .bus_req_i   (bus_req),
    .bus_adr_i   (bus_adr),
    .bus_ack_o   (bus_ack),
    .bus_rdata_o (bus_rdata),
    .bus_err_o   (bus_err)
  );

  // memory contents are the aligned word address xor a fixed pattern
  function automatic dc_word_t rule_word(input dc_addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  task automatic add_row(input op_e op, input dc_addr_t a, input logic c,
                         input exp_e e, input logic b);
    row_op.push_back(op);
    row_adr.push_back(a);
    row_cache.push_back(c);
    row_exp.push_back(e);
    row_word.push_back((e == EXP_DATA) ? rule_word(a) : '0);
    row_bus.push_back(b);
  endtask

  task automatic build_table();
    // cold miss then a hit in the same line
    add_row(OP_READ, 32'h0000_0104, 1'b1, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_010c, 1'b1, EXP_DATA, 1'b0);
    // lines a and b share set 2 and stay resident together
    add_row(OP_READ, 32'h0000_1020, 1'b1, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_2024, 1'b1, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_1028, 1'b1, EXP_DATA, 1'b0);
    add_row(OP_READ, 32'h0000_202c, 1'b1, EXP_DATA, 1'b0);
    // third tag evicts a while b still hits
    add_row(OP_READ, 32'h0000_3020, 1'b1, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_2020, 1'b1, EXP_DATA, 1'b0);
    add_row(OP_READ, 32'h0000_1024, 1'b1, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_3028, 1'b1, EXP_DATA, 1'b1);
    // uncached reads go out every time
    add_row(OP_READ, 32'h0000_4008, 1'b0, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_4008, 1'b0, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_0104, 1'b0, EXP_DATA, 1'b1);
    // the error region leaves the line invalid
    add_row(OP_READ, 32'h4000_0050, 1'b1, EXP_ERR,  1'b1);
    add_row(OP_READ, 32'h4000_0204, 1'b0, EXP_ERR,  1'b1);
    add_row(OP_READ, 32'h4000_0058, 1'b1, EXP_ERR,  1'b1);
    add_row(OP_READ, 32'h0000_0108, 1'b1, EXP_DATA, 1'b0);
    // flush drops every line
    add_row(OP_FLUSH, 32'h0000_0000, 1'b0, EXP_FLUSH, 1'b0);
    add_row(OP_READ, 32'h0000_0108, 1'b1, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_1020, 1'b1, EXP_DATA, 1'b1);
    add_row(OP_READ, 32'h0000_1020, 1'b1, EXP_DATA, 1'b0);
  endtask

  ////////////////////
  // checks
  ////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      row_errs++;
    end
  endtask

  task automatic check_word(input string name, input dc_word_t got, input dc_word_t exp);
    assert (got === exp)
    else
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      row_errs++;
    end
  endtask

  // hold the request until rvalid_o or err_o and sample on the falling edge
  task automatic run_read(input int r);
    int       cycles;
    int       beats;
    logic     bus_seen;
    logic     done;
    dc_addr_t exp_adr;

    cycles   = 0;
    beats    = 0;
    bus_seen = 1'b0;
    done     = 1'b0;
    @(posedge clk);
    req       <= 1'b1;
    adr       <= row_adr[r];
    cacheable <= row_cache[r];
    while (!done)
    begin
      @(negedge clk);
      cycles++;
      bus_seen = bus_seen | bus_req;
      // a burst steps through the line from its base, a single read asks for the word
      if (bus_req)
      begin
        if (row_cache[r])
          exp_adr = (row_adr[r] & 32'hffff_fff0) + 4 * beats;
        else
          exp_adr = row_adr[r] & 32'hffff_fffc;
        check_word("bus_adr_o", bus_adr, exp_adr);
        if (bus_ack)
          beats++;
      end
      if (rvalid || err)
      begin
        done = 1'b1;
        check_bit("stall_o", stall, 1'b0);
        check_bit("rvalid_o", rvalid, row_exp[r] == EXP_DATA);
        check_bit("err_o", err, row_exp[r] == EXP_ERR);
        if (row_exp[r] == EXP_DATA)
          check_word("rdata_o", rdata, row_word[r]);
        check_bit("bus_req_o", bus_seen, row_bus[r]);
        // a hit answers in the request cycle
        if (!row_bus[r])
        begin
          assert (cycles == 1)
          else
          begin
            $display("row %0d: hit answered after %0d cycles, not in the request cycle",
                     r, cycles);
            row_errs++;
          end
        end
      end
      else
        check_bit("stall_o", stall, 1'b1);
    end
    @(posedge clk);
    req <= 1'b0;
  endtask

  // one-cycle flush pulse then count the cycles armed_o stays low
  task automatic run_flush(input int r);
    int low_cycles;

    low_cycles = 0;
    @(posedge clk);
    flush_req <= 1'b1;
    @(posedge clk);
    flush_req <= 1'b0;
    @(negedge clk);
    while (!armed)
    begin
      low_cycles++;
      @(negedge clk);
    end
    // set walk plus the recover cycle
    assert (low_cycles == `DC_SETS + 1)
    else
    begin
      $display("row %0d: flush kept armed_o low for %0d cycles instead of %0d",
               r, low_cycles, `DC_SETS + 1);
      row_errs++;
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin : stimulus
    int    r;
    string verdict;

    req          = 1'b0;
    adr          = '0;
    cacheable    = 1'b0;
    flush_req    = 1'b0;
    table_ready  = 1'b0;
    row_errs     = 0;
    tests_passed = 0;
    tests_failed = 0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);

    for (r = 0; r < row_op.size(); r++)
    begin
      row_errs = 0;
      if (row_op[r] == OP_FLUSH)
        run_flush(r);
      else
        run_read(r);
      if (row_errs == 0)
      begin
        tests_passed++;
        verdict = "pass";
      end
      else
      begin
        tests_failed++;
        verdict = "fail";
      end
      if (row_op[r] == OP_FLUSH)
        $display("row %0d flush: %s", r, verdict);
      else
        $display("row %0d read %h cacheable %b: %s", r, row_adr[r], row_cache[r], verdict);
    end

    $display("tests %0d, passed %0d, failed %0d", row_op.size(), tests_passed, tests_failed);
    if (tests_failed == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // ends a run that stops making progress
  initial
  begin : watchdog
    int limit;

    wait (table_ready === 1'b1);
    limit = row_op.size() * ROW_CYCLES;
    wait (rst_n === 1'b1);
    repeat (limit) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_mem.sv
logic/dcache_biu.sv
logic/dcache_hit.sv
logic/dcache_top.sv
verification/tb_clkgen.sv
verification/tb_bus_mem.sv
verification/tb_dcache.sv
